//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 64;
    localparam int SHAMT_W = 6;
    localparam int DIV_CYCLES = XLEN; // One quotient bit per cycle

    // Major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        LUI       = 5'b01101,
        AUIPC     = 5'b00101,
        OP_IMM    = 5'b00100,
        OP_IMM_32 = 5'b00110,
        OP        = 5'b01100,
        OP_32     = 5'b01110
    } opcode_e;

    typedef enum logic [3:0] {
        EXC_NONE          = 4'd0,
        EXC_ILLEGAL_INSTR = 4'd2 // mcause encoding
    } trap_cause_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Base integer funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101; // Also SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // M extension funct3
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

endpackage

`default_nettype wire

//--- exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              i_valid,
    input  wire exec_pkg::opcode_e           i_opcode,
    input  wire [2:0]                        i_funct3,
    input  wire [6:0]                        i_funct7,
    input  wire [exec_pkg::XLEN-1:0]         i_alu_result,
    input  wire                              i_alu_exception,
    input  wire [2*exec_pkg::XLEN-1:0]       i_mul_product,
    input  wire                              i_div_done,
    input  wire [exec_pkg::XLEN-1:0]         i_div_result,
    output logic                             o_mul_start,
    output logic                             o_div_start,
    output logic                             o_valid,
    output logic                             o_exception,
    output exec_pkg::trap_cause_e            o_trap_cause,
    output logic [exec_pkg::XLEN-1:0]        o_result
);

    localparam int XLEN = exec_pkg::XLEN;

    logic                 is_muldiv;
    exec_pkg::unit_e      unit;
    exec_pkg::unit_e      unit_q;
    exec_pkg::opcode_e    opcode_q;
    logic [2:0]           funct3_q;
    logic                 pending;
    logic                 mul_done;
    logic                 div_done;
    logic [XLEN-1:0]      mul_word;
    logic                 mul_illegal;
    logic                 sel_valid;
    logic                 sel_exc;
    logic [XLEN-1:0]      sel_result;

    assign is_muldiv = (i_opcode == exec_pkg::OP || i_opcode == exec_pkg::OP_32) &&
                       i_funct7 == exec_pkg::FUNCT7_MULDIV;
    assign unit = !is_muldiv ? exec_pkg::UNIT_ALU :
                  (i_funct3[2] ? exec_pkg::UNIT_DIV : exec_pkg::UNIT_MUL);

    assign o_mul_start = i_valid && unit == exec_pkg::UNIT_MUL;
    assign o_div_start = i_valid && unit == exec_pkg::UNIT_DIV;

    assign mul_done = pending && unit_q == exec_pkg::UNIT_MUL; // Product ready after one cycle
    assign div_done = pending && unit_q == exec_pkg::UNIT_DIV && i_div_done;

    always_comb begin
        mul_illegal = 1'b0;
        mul_word = i_mul_product[XLEN-1:0];
        if (opcode_q == exec_pkg::OP_32) begin
            mul_word = {{(XLEN-32){i_mul_product[31]}}, i_mul_product[31:0]}; // MULW
            mul_illegal = funct3_q != exec_pkg::F3_MUL;
        end else begin
            case (funct3_q)
                exec_pkg::F3_MULH, exec_pkg::F3_MULHSU, exec_pkg::F3_MULHU:
                    mul_word = i_mul_product[2*XLEN-1:XLEN];
                default: mul_word = i_mul_product[XLEN-1:0];
            endcase
        end
    end

    always_comb begin
        sel_valid = 1'b0;
        sel_exc = 1'b0;
        sel_result = i_alu_result;
        if (i_valid && unit == exec_pkg::UNIT_ALU) begin
            sel_valid = 1'b1;
            sel_exc = i_alu_exception;
        end else if (mul_done) begin
            sel_valid = 1'b1;
            sel_exc = mul_illegal;
            sel_result = mul_word;
        end else if (div_done) begin
            sel_valid = 1'b1;
            sel_result = i_div_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            unit_q <= exec_pkg::UNIT_ALU;
            o_valid <= 1'b0;
            o_exception <= 1'b0;
            o_trap_cause <= exec_pkg::EXC_NONE;
        end else begin
            o_valid <= sel_valid;
            o_exception <= sel_exc;
            o_trap_cause <= sel_exc ? exec_pkg::EXC_ILLEGAL_INSTR : exec_pkg::EXC_NONE;
            if (o_mul_start || o_div_start) begin
                pending <= 1'b1;
                unit_q <= unit;
            end else if (mul_done || div_done) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            opcode_q <= i_opcode;
            funct3_q <= i_funct3;
        end
        if (sel_valid)
            o_result <= sel_result;
    end

    a_no_issue_pending: assert property (@(posedge clk) disable iff (rst)
        pending |-> !i_valid);
    a_div_done_expected: assert property (@(posedge clk) disable iff (rst)
        i_div_done |-> pending && unit_q == exec_pkg::UNIT_DIV);

endmodule

`default_nettype wire

//--- exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire [exec_pkg::XLEN-1:0]  i_pc,
    input  wire exec_pkg::opcode_e    i_opcode,
    input  wire [2:0]                 i_funct3,
    input  wire [6:0]                 i_funct7,
    input  wire [11:0]                i_imm_i,
    input  wire [19:0]                i_imm_u,
    input  wire [exec_pkg::XLEN-1:0]  i_rs1_data,
    input  wire [exec_pkg::XLEN-1:0]  i_rs2_data,
    output logic [exec_pkg::XLEN-1:0] o_result,
    output logic                      o_exception
);

    localparam int XLEN = exec_pkg::XLEN;

    logic                        is_reg;
    logic                        arith;
    logic                        muldiv;
    logic                        f7_ok;
    logic                        w_f3_ok;
    logic [XLEN-1:0]             imm_u;
    logic [XLEN-1:0]             op_b;
    logic [exec_pkg::SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]             res64;
    logic [31:0]                 res32;

    assign is_reg = i_opcode == exec_pkg::OP || i_opcode == exec_pkg::OP_32;
    assign arith = i_funct7[5]; // Instruction bit 30 selects SUB and SRA
    assign muldiv = i_funct7 == exec_pkg::FUNCT7_MULDIV;
    assign f7_ok = i_funct7 == 7'b0000000 || (i_funct7 == 7'b0100000 &&
                   (i_funct3 == exec_pkg::F3_ADD || i_funct3 == exec_pkg::F3_SRL));
    assign w_f3_ok = i_funct3 == exec_pkg::F3_ADD || i_funct3 == exec_pkg::F3_SLL ||
                     i_funct3 == exec_pkg::F3_SRL;

    assign imm_u = {{(XLEN-32){i_imm_u[19]}}, i_imm_u, 12'b0};
    assign op_b = is_reg ? i_rs2_data : {{(XLEN-12){i_imm_i[11]}}, i_imm_i};
    assign shamt = op_b[exec_pkg::SHAMT_W-1:0];

    always_comb begin
        res64 = '0;
        case (i_funct3)
            exec_pkg::F3_ADD:  res64 = (is_reg && arith) ? i_rs1_data - op_b : i_rs1_data + op_b;
            exec_pkg::F3_SLL:  res64 = i_rs1_data << shamt;
            exec_pkg::F3_SLT:  res64 = {{(XLEN-1){1'b0}}, $signed(i_rs1_data) < $signed(op_b)};
            exec_pkg::F3_SLTU: res64 = {{(XLEN-1){1'b0}}, i_rs1_data < op_b};
            exec_pkg::F3_XOR:  res64 = i_rs1_data ^ op_b;
            exec_pkg::F3_SRL: begin
                if (arith)
                    res64 = $signed(i_rs1_data) >>> shamt;
                else
                    res64 = i_rs1_data >> shamt;
            end
            exec_pkg::F3_OR:   res64 = i_rs1_data | op_b;
            exec_pkg::F3_AND:  res64 = i_rs1_data & op_b;
            default:           res64 = '0;
        endcase
    end

    // Word forms exist only for ADD, SLL and SRL
    always_comb begin
        res32 = (is_reg && arith) ? i_rs1_data[31:0] - op_b[31:0] : i_rs1_data[31:0] + op_b[31:0];
        if (i_funct3 == exec_pkg::F3_SLL) begin
            res32 = i_rs1_data[31:0] << shamt[4:0];
        end else if (i_funct3 == exec_pkg::F3_SRL) begin
            if (arith)
                res32 = $signed(i_rs1_data[31:0]) >>> shamt[4:0];
            else
                res32 = i_rs1_data[31:0] >> shamt[4:0];
        end
    end

    always_comb begin
        o_exception = 1'b0;
        o_result = res64;
        case (i_opcode)
            exec_pkg::LUI:   o_result = imm_u;
            exec_pkg::AUIPC: o_result = i_pc + imm_u;
            exec_pkg::OP_IMM: begin
                if (i_funct3 == exec_pkg::F3_SLL)
                    o_exception = i_imm_i[11:6] != '0;
                else if (i_funct3 == exec_pkg::F3_SRL)
                    o_exception = i_imm_i[11] || i_imm_i[9:6] != '0;
            end
            exec_pkg::OP_IMM_32: begin
                o_result = {{(XLEN-32){res32[31]}}, res32};
                if (i_funct3 == exec_pkg::F3_SLL)
                    o_exception = i_imm_i[11:5] != '0;
                else if (i_funct3 == exec_pkg::F3_SRL)
                    o_exception = i_imm_i[11] || i_imm_i[9:5] != '0;
                else
                    o_exception = !w_f3_ok;
            end
            exec_pkg::OP: o_exception = !muldiv && !f7_ok; // M forms go to mul/div
            exec_pkg::OP_32: begin
                o_result = {{(XLEN-32){res32[31]}}, res32};
                o_exception = !muldiv && (!f7_ok || !w_f3_ok);
            end
            default: o_exception = 1'b1; // Unknown opcode
        endcase
    end

    always_comb begin
        if (!o_exception)
            assert (!$isunknown(o_result)) else $error("ALU result unknown");
    end

endmodule

`default_nettype wire

//--- exec_mul.sv
`timescale 1ns/1ps
`default_nettype none

module exec_mul (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_start,
    input  wire [2:0]                   i_funct3,
    input  wire [exec_pkg::XLEN-1:0]    i_rs1_data,
    input  wire [exec_pkg::XLEN-1:0]    i_rs2_data,
    output logic [2*exec_pkg::XLEN-1:0] o_product
);

    localparam int XLEN = exec_pkg::XLEN;

    logic              rs1_signed;
    logic              rs2_signed;
    logic              rs1_neg;
    logic              rs2_neg;
    logic [XLEN-1:0]   corr;
    logic [XLEN-1:0]   corr_q;
    logic [2*XLEN-1:0] prod_q;

    assign rs1_signed = i_funct3 == exec_pkg::F3_MULH || i_funct3 == exec_pkg::F3_MULHSU;
    assign rs2_signed = i_funct3 == exec_pkg::F3_MULH;
    assign rs1_neg = rs1_signed && i_rs1_data[XLEN-1];
    assign rs2_neg = rs2_signed && i_rs2_data[XLEN-1];

    // A negative operand weighs -2^XLEN more in two's complement
    assign corr = (rs1_neg ? -i_rs2_data : '0) + (rs2_neg ? -i_rs1_data : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q <= '0;
            corr_q <= '0;
        end else if (i_start) begin
            prod_q <= i_rs1_data * i_rs2_data; // Unsigned full product
            corr_q <= corr;
        end
    end

    assign o_product = {prod_q[2*XLEN-1:XLEN] + corr_q, prod_q[XLEN-1:0]};

endmodule

`default_nettype wire

//--- exec_div.sv
`timescale 1ns/1ps
`default_nettype none

module exec_div (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_start,
    input  wire                       i_word,
    input  wire [2:0]                 i_funct3,
    input  wire [exec_pkg::XLEN-1:0]  i_rs1_data,
    input  wire [exec_pkg::XLEN-1:0]  i_rs2_data,
    output logic                      o_done,
    output logic [exec_pkg::XLEN-1:0] o_result
);

    localparam int XLEN = exec_pkg::XLEN;
    localparam int CNT_W = $clog2(exec_pkg::DIV_CYCLES);

    logic              is_signed;
    logic [XLEN-1:0]   a_ext;
    logic [XLEN-1:0]   b_ext;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   min_val;
    logic              busy;
    logic [CNT_W-1:0]  count;
    logic [XLEN-1:0]   quo;
    logic [XLEN-1:0]   rem;
    logic [XLEN-1:0]   divisor;
    logic [XLEN:0]     shifted;
    logic [XLEN:0]     diff;
    logic [XLEN-1:0]   dividend_q;
    logic              by_zero_q;
    logic              ovf_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              word_q;
    logic [2:0]        funct3_q;
    logic [XLEN-1:0]   q_fix;
    logic [XLEN-1:0]   r_fix;
    logic [XLEN-1:0]   res;

    assign is_signed = i_funct3 == exec_pkg::F3_DIV || i_funct3 == exec_pkg::F3_REM;
    assign a_ext = !i_word ? i_rs1_data :
                   {{(XLEN-32){is_signed && i_rs1_data[31]}}, i_rs1_data[31:0]};
    assign b_ext = !i_word ? i_rs2_data :
                   {{(XLEN-32){is_signed && i_rs2_data[31]}}, i_rs2_data[31:0]};
    assign a_neg = is_signed && a_ext[XLEN-1];
    assign b_neg = is_signed && b_ext[XLEN-1];
    assign min_val = i_word ? {{(XLEN-31){1'b1}}, 31'b0} : {1'b1, {(XLEN-1){1'b0}}};

    assign shifted = {rem, quo[XLEN-1]};
    assign diff = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            count <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CNT_W'(exec_pkg::DIV_CYCLES - 1)) begin
                    busy <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            quo <= a_neg ? -a_ext : a_ext; // Dividend magnitude
            rem <= '0;
            divisor <= b_neg ? -b_ext : b_ext;
            dividend_q <= a_ext;
            by_zero_q <= b_ext == '0;
            ovf_q <= is_signed && a_ext == min_val && b_ext == '1;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg; // Remainder takes the dividend's sign
            word_q <= i_word;
            funct3_q <= i_funct3;
        end else if (busy) begin
            if (!diff[XLEN]) begin // No borrow, divisor fits
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign q_fix = q_neg_q ? -quo : quo;
    assign r_fix = r_neg_q ? -rem : rem;

    always_comb begin
        case (funct3_q)
            exec_pkg::F3_DIV:  res = by_zero_q ? '1 : (ovf_q ? dividend_q : q_fix);
            exec_pkg::F3_DIVU: res = by_zero_q ? '1 : quo;
            exec_pkg::F3_REM:  res = by_zero_q ? dividend_q : (ovf_q ? '0 : r_fix);
            exec_pkg::F3_REMU: res = by_zero_q ? dividend_q : rem;
            default:           res = '0;
        endcase
    end

    assign o_result = word_q ? {{(XLEN-32){res[31]}}, res[31:0]} : res;

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) i_start |-> !busy);

endmodule

`default_nettype wire

//--- exec_int.sv
`timescale 1ns/1ps
`default_nettype none

module exec_int (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_valid,
    input  wire [exec_pkg::XLEN-1:0]   i_pc,
    input  wire exec_pkg::opcode_e     i_opcode,
    input  wire [2:0]                  i_funct3,
    input  wire [6:0]                  i_funct7,
    input  wire [11:0]                 i_imm_i,
    input  wire [19:0]                 i_imm_u,
    input  wire [exec_pkg::XLEN-1:0]   i_rs1_data,
    input  wire [exec_pkg::XLEN-1:0]   i_rs2_data,
    output logic                       o_valid,
    output logic                       o_exception,
    output exec_pkg::trap_cause_e      o_trap_cause,
    output logic [exec_pkg::XLEN-1:0]  o_result
);

    localparam int XLEN = exec_pkg::XLEN;

    logic [XLEN-1:0]   alu_result;
    logic              alu_exception;
    logic              mul_start;
    logic [2*XLEN-1:0] mul_product;
    logic              div_start;
    logic              div_done;
    logic [XLEN-1:0]   div_result;
    logic              div_word;

    assign div_word = i_opcode == exec_pkg::OP_32; // DIVW and friends

    exec_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_valid         (i_valid),
        .i_opcode        (i_opcode),
        .i_funct3        (i_funct3),
        .i_funct7        (i_funct7),
        .i_alu_result    (alu_result),
        .i_alu_exception (alu_exception),
        .i_mul_product   (mul_product),
        .i_div_done      (div_done),
        .i_div_result    (div_result),
        .o_mul_start     (mul_start),
        .o_div_start     (div_start),
        .o_valid         (o_valid),
        .o_exception     (o_exception),
        .o_trap_cause    (o_trap_cause),
        .o_result        (o_result)
    );

    exec_alu u_alu (
        .i_pc        (i_pc),
        .i_opcode    (i_opcode),
        .i_funct3    (i_funct3),
        .i_funct7    (i_funct7),
        .i_imm_i     (i_imm_i),
        .i_imm_u     (i_imm_u),
        .i_rs1_data  (i_rs1_data),
        .i_rs2_data  (i_rs2_data),
        .o_result    (alu_result),
        .o_exception (alu_exception)
    );

    exec_mul u_mul (
        .clk        (clk),
        .rst        (rst),
        .i_start    (mul_start),
        .i_funct3   (i_funct3),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_product  (mul_product)
    );

    exec_div u_div (
        .clk        (clk),
        .rst        (rst),
        .i_start    (div_start),
        .i_word     (div_word),
        .i_funct3   (i_funct3),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_done     (div_done),
        .o_result   (div_result)
    );

endmodule

`default_nettype wire

//--- tb_exec_int.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_int;

    localparam int XLEN = exec_pkg::XLEN;
    localparam int RESET_CYCLES = 5;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  i_valid;
    logic [XLEN-1:0]       i_pc;
    exec_pkg::opcode_e     i_opcode;
    logic [2:0]            i_funct3;
    logic [6:0]            i_funct7;
    logic [11:0]           i_imm_i;
    logic [19:0]           i_imm_u;
    logic [XLEN-1:0]       i_rs1_data;
    logic [XLEN-1:0]       i_rs2_data;
    logic                  o_valid;
    logic                  o_exception;
    exec_pkg::trap_cause_e o_trap_cause;
    logic [XLEN-1:0]       o_result;

    logic [7:0]      v_id[$];
    logic [4:0]      v_opcode[$];
    logic [2:0]      v_funct3[$];
    logic [6:0]      v_funct7[$];
    logic [11:0]     v_imm_i[$];
    logic [19:0]     v_imm_u[$];
    logic [XLEN-1:0] v_pc[$];
    logic [XLEN-1:0] v_rs1[$];
    logic [XLEN-1:0] v_rs2[$];
    logic [XLEN-1:0] v_result[$];
    logic            v_exc[$];

    bit loaded = 1'b0;
    int issued = 0;
    int seen = 0;

    exec_int u_exec_int (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_pc         (i_pc),
        .i_opcode     (i_opcode),
        .i_funct3     (i_funct3),
        .i_funct7     (i_funct7),
        .i_imm_i      (i_imm_i),
        .i_imm_u      (i_imm_u),
        .i_rs1_data   (i_rs1_data),
        .i_rs2_data   (i_rs2_data),
        .o_valid      (o_valid),
        .o_exception  (o_exception),
        .o_trap_cause (o_trap_cause),
        .o_result     (o_result)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic abort_run(input string why);
        $display("Test failures found");
        $fatal(1, "%s", why);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_result(input string name, input logic [XLEN-1:0] expected,
                                  input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run("Result mismatch");
        end
    endtask

    task automatic compare_exception(input string name, input bit exp_exc,
                                     input exec_pkg::trap_cause_e exp_cause,
                                     input logic act_exc,
                                     input exec_pkg::trap_cause_e act_cause);
        if (act_exc !== exp_exc || act_cause !== exp_cause) begin
            $display("FAILED %s: expected exception %0b cause %0d, actual exception %0b cause %0d",
                     name, exp_exc, exp_cause, act_exc, act_cause);
            abort_run("Exception mismatch");
        end
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [7:0] id;
        logic [4:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm_i;
        logic [19:0] imm_u;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] result;
        logic exc;
        fd = $fopen("exec_testdata.txt", "r");
        if (fd == 0)
            abort_run("Cannot open exec_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            n = 0;
            if (line.len() > 0 && line[0] != "#") // Skip column notes
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", id, op, f3, f7,
                            imm_i, imm_u, pc, rs1, rs2, result, exc);
            if (n == 11) begin
                v_id.push_back(id);
                v_opcode.push_back(op);
                v_funct3.push_back(f3);
                v_funct7.push_back(f7);
                v_imm_i.push_back(imm_i);
                v_imm_u.push_back(imm_u);
                v_pc.push_back(pc);
                v_rs1.push_back(rs1);
                v_rs2.push_back(rs2);
                v_result.push_back(result);
                v_exc.push_back(exc);
            end else if (n > 0) begin
                abort_run("Malformed line in exec_testdata.txt");
            end
        end
        $fclose(fd);
        if (v_id.size() == 0)
            abort_run("No vectors found in exec_testdata.txt");
    endtask

    task automatic issue(input int k);
        i_opcode = exec_pkg::opcode_e'(v_opcode[k]);
        i_funct3 = v_funct3[k];
        i_funct7 = v_funct7[k];
        i_imm_i = v_imm_i[k];
        i_imm_u = v_imm_u[k];
        i_pc = v_pc[k];
        i_rs1_data = v_rs1[k];
        i_rs2_data = v_rs2[k];
        i_valid = 1'b1;
        issued++;
    endtask

    // Count result pulses, never more than instructions issued
    always @(negedge clk) begin
        if (!rst) begin
            if (o_valid !== 1'b0 && o_valid !== 1'b1)
                abort_run("o_valid is unknown after reset");
            if (o_valid === 1'b1) begin
                seen++;
                if (seen > issued)
                    abort_run("o_valid pulsed with no instruction outstanding");
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (RESET_CYCLES + 8 + v_id.size() * (exec_pkg::DIV_CYCLES + 8)) @(posedge clk);
        abort_run("Timed out waiting for a result");
    end

    initial begin : stimulus
        int gap;
        logic [31:0] seed;
        string name;
        exec_pkg::trap_cause_e exp_cause;
        seed = 32'hc167;
        rst = 1'b1;
        i_valid = 1'b0;
        i_pc = '0;
        i_opcode = exec_pkg::OP;
        i_funct3 = '0;
        i_funct7 = '0;
        i_imm_i = '0;
        i_imm_u = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) begin // Idle, the monitor expects no pulse
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < v_id.size(); k++) begin
            issue(k);
            @(posedge clk);
            #1;
            i_valid = 1'b0;
            while (o_valid !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            name = $sformatf("test %h", v_id[k]);
            exp_cause = v_exc[k] ? exec_pkg::EXC_ILLEGAL_INSTR : exec_pkg::EXC_NONE;
            compare_exception(name, v_exc[k], exp_cause, o_exception, o_trap_cause);
            if (!v_exc[k])
                compare_result(name, v_result[k], o_result);
            seed = lcg_next(seed);
            gap = int'(seed[31:30]); // Zero gives back-to-back issue
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (4) @(posedge clk); // Room for a stray pulse
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_testdata.txt
# id opcode funct3 funct7 imm_i imm_u pc rs1 rs2 expected_result expected_exception (hex)
# opcode 0d LUI, 05 AUIPC, 04 OP-IMM, 06 OP-IMM-32, 0c OP, 0e OP-32
01 0c 0 00 000 00000 0 7fffffffffffffff 1 8000000000000000 0
02 0c 0 20 000 00000 0 3 5 fffffffffffffffe 0
03 04 0 7f fff 00000 0 0 0 ffffffffffffffff 0
04 0c 4 00 000 00000 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 f0f0f0f0f0f0f0f0 0
05 0c 6 00 000 00000 0 f0 0f ff 0
06 04 7 07 0f0 00000 0 123456789abcdef0 0 f0 0
07 0c 2 00 000 00000 0 ffffffffffffffff 1 1 0
08 0c 3 00 000 00000 0 ffffffffffffffff 1 0 0
09 0c 1 00 000 00000 0 1 7f 8000000000000000 0
0a 0c 5 00 000 00000 0 8000000000000000 4 0800000000000000 0
0b 0c 5 20 000 00000 0 8000000000000000 4 f800000000000000 0
0c 04 5 21 43f 00000 0 8000000000000000 0 ffffffffffffffff 0
0d 04 1 01 020 00000 0 12345678 0 1234567800000000 0
0e 0e 0 00 000 00000 0 7fffffff 1 ffffffff80000000 0
0f 0e 0 20 000 00000 0 100000000 1 ffffffffffffffff 0
10 0e 1 00 000 00000 0 3 1e ffffffffc0000000 0
11 0e 5 00 000 00000 0 ffffffff80000000 4 8000000 0
12 0e 5 20 000 00000 0 80000000 4 fffffffff8000000 0
13 06 0 7f fff 00000 0 80000000 0 7fffffff 0
14 0d 0 00 000 80000 0 0 0 ffffffff80000000 0
15 05 0 00 000 fffff 10000 0 0 f000 0
20 0c 0 01 000 00000 0 ffffffffffffffff ffffffffffffffff 1 0
21 0c 1 01 000 00000 0 ffffffffffffffff ffffffffffffffff 0 0
22 0c 3 01 000 00000 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
23 0c 2 01 000 00000 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0
24 0c 1 01 000 00000 0 8000000000000000 8000000000000000 4000000000000000 0
25 0c 1 01 000 00000 0 8000000000000000 2 ffffffffffffffff 0
26 0c 2 01 000 00000 0 2 8000000000000000 1 0
27 0c 3 01 000 00000 0 100000000 300000000 3 0
28 0c 0 01 000 00000 0 fffffffffffffffd 7 ffffffffffffffeb 0
29 0e 0 01 000 00000 0 123456787fffffff 2 fffffffffffffffe 0
30 0c 4 01 000 00000 0 7 2 3 0
31 0c 4 01 000 00000 0 fffffffffffffff9 2 fffffffffffffffd 0
32 0c 4 01 000 00000 0 7 fffffffffffffffe fffffffffffffffd 0
33 0c 4 01 000 00000 0 fffffffffffffff9 fffffffffffffffe 3 0
34 0c 6 01 000 00000 0 7 2 1 0
35 0c 6 01 000 00000 0 fffffffffffffff9 2 ffffffffffffffff 0
36 0c 6 01 000 00000 0 7 fffffffffffffffe 1 0
37 0c 6 01 000 00000 0 fffffffffffffff9 fffffffffffffffe ffffffffffffffff 0
38 0c 5 01 000 00000 0 ffffffffffffffff 2 7fffffffffffffff 0
39 0c 7 01 000 00000 0 ffffffffffffffff 10 f 0
3a 0e 4 01 000 00000 0 fffffff9 2 fffffffffffffffd 0
3b 0e 6 01 000 00000 0 fffffff9 2 ffffffffffffffff 0
3c 0e 5 01 000 00000 0 ffffffff 2 7fffffff 0
3d 0e 7 01 000 00000 0 1234567800000007 3 1 0
40 0c 4 01 000 00000 0 1234 0 ffffffffffffffff 0
41 0c 6 01 000 00000 0 1234 0 1234 0
42 0c 4 01 000 00000 0 8000000000000000 ffffffffffffffff 8000000000000000 0
43 0c 6 01 000 00000 0 8000000000000000 ffffffffffffffff 0 0
44 0e 4 01 000 00000 0 80000000 ffffffff ffffffff80000000 0
45 0e 6 01 000 00000 0 80000000 ffffffff 0 0
46 0e 4 01 000 00000 0 5 100000000 ffffffffffffffff 0
47 0e 6 01 000 00000 0 180000000 100000000 ffffffff80000000 0
50 04 1 02 040 00000 0 1 0 0 1
51 04 5 40 805 00000 0 1 0 0 1
52 06 1 01 020 00000 0 1 0 0 1
53 06 2 00 001 00000 0 1 0 0 1
54 0e 4 00 000 00000 0 1 2 0 1
55 0e 1 01 000 00000 0 1 2 0 1
56 1c 0 00 000 00000 0 1 2 0 1
57 0c 0 10 000 00000 0 1 2 0 1
58 0c 0 00 000 00000 0 1 2 3 0

//--- filelist.f
exec_pkg.sv
exec_ctrl.sv
exec_alu.sv
exec_mul.sv
exec_div.sv
exec_int.sv
tb_exec_int.sv

//--- Makefile
# Verilator build and run for the integer execution unit

VERILATOR ?= verilator
TOP       ?= tb_exec_int
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
